//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= tb_axil_subsys
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
PASS_TEXT = Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- axil_csr_block.sv
`timescale 1ns/1ps
`default_nettype none

module axil_csr_block import axil_pkg::*; #(
  parameter int ADDR_WIDTH = 16,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  axil_if.target                bus,
  output logic [WAIT_WIDTH-1:0] wait_cycles
);

  localparam logic [ADDR_WIDTH-1:0] ADDR_ID = ADDR_WIDTH'(CSR_ADDR_ID);
  localparam logic [ADDR_WIDTH-1:0] ADDR_SCRATCH = ADDR_WIDTH'(CSR_ADDR_SCRATCH);
  localparam logic [ADDR_WIDTH-1:0] ADDR_WAIT = ADDR_WIDTH'(CSR_ADDR_WAIT);

  logic                      up_q;
  logic                      bvalid_q;
  logic                      rvalid_q;
  logic [DATA_WIDTH-1:0]     scratch_q;
  logic [WAIT_WIDTH-1:0]     wait_q;
  logic [AXI_RESP_WIDTH-1:0] bresp_q;
  logic [AXI_RESP_WIDTH-1:0] rresp_q;
  logic [DATA_WIDTH-1:0]     rdata_q;
  logic                      wr_fire;
  logic                      rd_fire;
  logic                      wr_scratch;
  logic                      wr_wait;

  // One pending response per direction
  assign bus.awready = up_q && !bvalid_q;
  assign bus.wready = up_q && !bvalid_q;
  assign bus.arready = up_q && !rvalid_q;
  assign wr_fire = bus.awvalid && bus.awready && bus.wvalid;
  assign rd_fire = bus.arvalid && bus.arready;

  assign wr_scratch = (bus.awaddr == ADDR_SCRATCH);
  assign wr_wait = (bus.awaddr == ADDR_WAIT);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      up_q <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      scratch_q <= '0;
      wait_q <= '0;
    end else begin
      up_q <= 1'b1;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        for (int b = 0; b < DATA_WIDTH / 8; b++) begin
          if (wr_scratch && bus.wstrb[b]) begin
            scratch_q[b*8 +: 8] <= bus.wdata[b*8 +: 8];
          end
        end
        if (wr_wait && bus.wstrb[0]) begin
          wait_q <= bus.wdata[WAIT_WIDTH-1:0];
        end
      end else if (bus.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (bus.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Response payloads, ID is read-only
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp_q <= (wr_scratch || wr_wait) ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      rresp_q <= RESP_OKAY;
      case (bus.araddr)
        ADDR_ID:      rdata_q <= DATA_WIDTH'(CSR_ID_VALUE);
        ADDR_SCRATCH: rdata_q <= scratch_q;
        ADDR_WAIT:    rdata_q <= DATA_WIDTH'(wait_q);
        default: begin
          rdata_q <= '0;
          rresp_q <= RESP_SLVERR;
        end
      endcase
    end
  end

  assign bus.bvalid = bvalid_q;
  assign bus.bresp = bresp_q;
  assign bus.rvalid = rvalid_q;
  assign bus.rresp = rresp_q;
  assign bus.rdata = rdata_q;
  assign wait_cycles = wait_q;

endmodule

`default_nettype wire

//--- axil_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axil_if import axil_pkg::*; #(
  parameter int ADDR_WIDTH = 16,
  parameter int DATA_WIDTH = 32
);

  logic [ADDR_WIDTH-1:0]     awaddr;
  logic [AXI_PROT_WIDTH-1:0] awprot;
  logic                      awvalid;
  logic                      awready;
  logic [DATA_WIDTH-1:0]     wdata;
  logic [DATA_WIDTH/8-1:0]   wstrb;
  logic                      wvalid;
  logic                      wready;
  logic [AXI_RESP_WIDTH-1:0] bresp;
  logic                      bvalid;
  logic                      bready;
  logic [ADDR_WIDTH-1:0]     araddr;
  logic [AXI_PROT_WIDTH-1:0] arprot;
  logic                      arvalid;
  logic                      arready;
  logic [DATA_WIDTH-1:0]     rdata;
  logic [AXI_RESP_WIDTH-1:0] rresp;
  logic                      rvalid;
  logic                      rready;

  modport initiator (
    output awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
    output araddr, arprot, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport target (
    input  awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
    input  araddr, arprot, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

`default_nettype wire

//--- axil_mem_array.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_array #(
  parameter int MEM_WORDS = 64,
  parameter int DATA_WIDTH = 32,
  localparam int IDX_W = $clog2(MEM_WORDS)
) (
  input  logic                    clk,
  input  logic                    we,
  input  logic [IDX_W-1:0]        waddr,
  input  logic [IDX_W-1:0]        raddr,
  input  logic [DATA_WIDTH-1:0]   wdata,
  input  logic [DATA_WIDTH/8-1:0] wstrb,
  input  logic                    re,
  output logic [DATA_WIDTH-1:0]   rdata
);

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

  // Byte-lane write merge
  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < DATA_WIDTH / 8; b++) begin
        if (wstrb[b]) begin
          mem[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

//--- axil_mem_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_fsm import axil_pkg::*; #(
  parameter int ADDR_WIDTH = 16,
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS = 64
) (
  input  logic                  clk,
  input  logic                  rst_n,
  axil_if.target                bus,
  input  logic [WAIT_WIDTH-1:0] wait_cycles
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam logic [31:0] MEM_LO = 32'(MEM_BASE_ADDR);
  localparam logic [31:0] MEM_HI = MEM_LO + 32'(MEM_WORDS * 4);

  localparam logic [2:0] IDLE = 3'd0;
  localparam logic [2:0] WRITE_WAIT = 3'd1;
  localparam logic [2:0] WRITE_RESP = 3'd2;
  localparam logic [2:0] READ_WAIT = 3'd3;
  localparam logic [2:0] READ_RESP = 3'd4;

  logic [2:0]              state_q;
  logic                    up_q;
  logic                    armed_q;
  logic [ADDR_WIDTH-1:0]   addr_q;
  logic [DATA_WIDTH-1:0]   wdata_q;
  logic [DATA_WIDTH/8-1:0] wstrb_q;
  logic [31:0]             offset;
  logic                    in_range;
  logic                    in_wait;
  logic                    wait_over;
  logic                    timer_done;
  logic                    wr_fire;
  logic                    rd_fire;
  logic [DATA_WIDTH-1:0]   arr_rdata;

  // Writes win a tie in IDLE
  assign bus.awready = up_q && (state_q == IDLE);
  assign bus.wready = up_q && (state_q == IDLE);
  assign bus.arready = up_q && (state_q == IDLE) && !(bus.awvalid && bus.wvalid);
  assign wr_fire = bus.awvalid && bus.awready && bus.wvalid;
  assign rd_fire = bus.arvalid && bus.arready;

  assign offset = 32'(addr_q) - MEM_LO;
  assign in_range = (32'(addr_q) >= MEM_LO) && (32'(addr_q) < MEM_HI);

  // First wait cycle loads the timer, which puts the response at N+2
  assign in_wait = (state_q == WRITE_WAIT) || (state_q == READ_WAIT);
  assign wait_over = in_wait && armed_q && timer_done;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      up_q <= 1'b0;
      armed_q <= 1'b0;
    end else begin
      up_q <= 1'b1;
      armed_q <= in_wait && !wait_over;
      case (state_q)
        IDLE: begin
          if (wr_fire) begin
            state_q <= WRITE_WAIT;
          end else if (rd_fire) begin
            state_q <= READ_WAIT;
          end
        end
        WRITE_WAIT: if (wait_over) state_q <= WRITE_RESP;
        WRITE_RESP: if (bus.bready) state_q <= IDLE;
        READ_WAIT:  if (wait_over) state_q <= READ_RESP;
        READ_RESP:  if (bus.rready) state_q <= IDLE;
        default:    state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      addr_q <= bus.awaddr;
      wdata_q <= bus.wdata;
      wstrb_q <= bus.wstrb;
    end else if (rd_fire) begin
      addr_q <= bus.araddr;
    end
  end

  wait_timer wait_timer_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (in_wait && !armed_q),
    .load_value (wait_cycles),
    .done       (timer_done)
  );

  axil_mem_array #(
    .MEM_WORDS  (MEM_WORDS),
    .DATA_WIDTH (DATA_WIDTH)
  ) axil_mem_array_inst (
    .clk   (clk),
    .we    ((state_q == WRITE_WAIT) && wait_over && in_range),
    .waddr (offset[IDX_W+1:2]),
    .raddr (offset[IDX_W+1:2]),
    .wdata (wdata_q),
    .wstrb (wstrb_q),
    .re    ((state_q == READ_WAIT) && wait_over && in_range),
    .rdata (arr_rdata)
  );

  // Out-of-window accesses answer DECERR with zero data
  assign bus.bvalid = (state_q == WRITE_RESP);
  assign bus.bresp = in_range ? RESP_OKAY : RESP_DECERR;
  assign bus.rvalid = (state_q == READ_RESP);
  assign bus.rresp = in_range ? RESP_OKAY : RESP_DECERR;
  assign bus.rdata = in_range ? arr_rdata : '0;

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n) state_q <= READ_RESP);

  a_one_resp: assert property (@(posedge clk) disable iff (!rst_n)
    !(bus.bvalid && bus.rvalid));

endmodule

`default_nettype wire

//--- axil_pkg.sv
`default_nettype none

package axil_pkg;

  // Bus field widths
  localparam int AXI_RESP_WIDTH = 2;
  localparam int AXI_PROT_WIDTH = 3;
  localparam int WAIT_WIDTH = 4;

  // Response codes
  localparam logic [AXI_RESP_WIDTH-1:0] RESP_OKAY = 2'd0;
  localparam logic [AXI_RESP_WIDTH-1:0] RESP_SLVERR = 2'd2;
  localparam logic [AXI_RESP_WIDTH-1:0] RESP_DECERR = 2'd3;

  // Register block map
  localparam logic [31:0] CSR_ID_VALUE = 32'h5A11_0001;
  localparam logic [15:0] CSR_ADDR_ID = 16'h0000;
  localparam logic [15:0] CSR_ADDR_SCRATCH = 16'h0004;
  localparam logic [15:0] CSR_ADDR_WAIT = 16'h0008;

  // Memory window start, the size comes from MEM_WORDS
  localparam logic [15:0] MEM_BASE_ADDR = 16'h1000;

endpackage

`default_nettype wire

//--- axil_split.sv
`timescale 1ns/1ps
`default_nettype none

module axil_split import axil_pkg::*; #(
  parameter int ADDR_WIDTH = 16,
  parameter int DATA_WIDTH = 32,
  parameter logic [ADDR_WIDTH-1:0] BRANCH_START_ADDR = 'h0,
  parameter logic [ADDR_WIDTH-1:0] BRANCH_END_ADDR = 'hFF
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [ADDR_WIDTH-1:0]     root_awaddr,
  input  logic [AXI_PROT_WIDTH-1:0] root_awprot,
  input  logic                      root_awvalid,
  output logic                      root_awready,
  input  logic [DATA_WIDTH-1:0]     root_wdata,
  input  logic [DATA_WIDTH/8-1:0]   root_wstrb,
  input  logic                      root_wvalid,
  output logic                      root_wready,
  output logic [AXI_RESP_WIDTH-1:0] root_bresp,
  output logic                      root_bvalid,
  input  logic                      root_bready,
  input  logic [ADDR_WIDTH-1:0]     root_araddr,
  input  logic [AXI_PROT_WIDTH-1:0] root_arprot,
  input  logic                      root_arvalid,
  output logic                      root_arready,
  output logic [DATA_WIDTH-1:0]     root_rdata,
  output logic [AXI_RESP_WIDTH-1:0] root_rresp,
  output logic                      root_rvalid,
  input  logic                      root_rready,
  axil_if.initiator                 branch,
  axil_if.initiator                 trunk
);

  logic       aw_in_branch;
  logic       ar_in_branch;
  logic       wr_both;
  logic [1:0] wr_grant;
  logic [1:0] rd_grant;

  // ------------------------------
  // Request path
  // ------------------------------
  assign aw_in_branch = (root_awaddr >= BRANCH_START_ADDR) && (root_awaddr <= BRANCH_END_ADDR);
  assign ar_in_branch = (root_araddr >= BRANCH_START_ADDR) && (root_araddr <= BRANCH_END_ADDR);

  // AW and W only go out together
  assign wr_both = root_awvalid && root_wvalid;
  assign branch.awvalid = wr_both && aw_in_branch;
  assign branch.wvalid = wr_both && aw_in_branch;
  assign trunk.awvalid = wr_both && !aw_in_branch;
  assign trunk.wvalid = wr_both && !aw_in_branch;
  assign root_awready = (branch.awvalid && branch.awready) || (trunk.awvalid && trunk.awready);
  assign root_wready = (branch.wvalid && branch.wready) || (trunk.wvalid && trunk.wready);

  assign branch.arvalid = root_arvalid && ar_in_branch;
  assign trunk.arvalid = root_arvalid && !ar_in_branch;
  assign root_arready = (branch.arvalid && branch.arready) || (trunk.arvalid && trunk.arready);

  // Payloads go to both targets
  assign branch.awaddr = root_awaddr;
  assign trunk.awaddr = root_awaddr;
  assign branch.awprot = root_awprot;
  assign trunk.awprot = root_awprot;
  assign branch.wdata = root_wdata;
  assign trunk.wdata = root_wdata;
  assign branch.wstrb = root_wstrb;
  assign trunk.wstrb = root_wstrb;
  assign branch.araddr = root_araddr;
  assign trunk.araddr = root_araddr;
  assign branch.arprot = root_arprot;
  assign trunk.arprot = root_arprot;

  // ------------------------------
  // Response merge, bit 0 branch, bit 1 trunk
  // ------------------------------
  rr_arb wr_arb (
    .clk     (clk),
    .rst_n   (rst_n),
    .request ({trunk.bvalid, branch.bvalid}),
    .update  (root_bvalid && root_bready),
    .grant   (wr_grant)
  );

  assign root_bvalid = |wr_grant;
  assign root_bresp = wr_grant[1] ? trunk.bresp : branch.bresp;
  assign branch.bready = wr_grant[0] && root_bready;
  assign trunk.bready = wr_grant[1] && root_bready;

  rr_arb rd_arb (
    .clk     (clk),
    .rst_n   (rst_n),
    .request ({trunk.rvalid, branch.rvalid}),
    .update  (root_rvalid && root_rready),
    .grant   (rd_grant)
  );

  assign root_rvalid = |rd_grant;
  assign root_rresp = rd_grant[1] ? trunk.rresp : branch.rresp;
  assign root_rdata = rd_grant[1] ? trunk.rdata : branch.rdata;
  assign branch.rready = rd_grant[0] && root_rready;
  assign trunk.rready = rd_grant[1] && root_rready;

  a_window_order: assert property (@(posedge clk) BRANCH_END_ADDR > BRANCH_START_ADDR);

  a_root_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
    root_bvalid && !root_bready |=> root_bvalid && $stable(root_bresp));

  a_root_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
    root_rvalid && !root_rready |=> root_rvalid && $stable(root_rdata) && $stable(root_rresp));

endmodule

`default_nettype wire

//--- axil_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module axil_subsys_top import axil_pkg::*; #(
  parameter int ADDR_WIDTH = 16,
  parameter int DATA_WIDTH = 32,
  parameter logic [ADDR_WIDTH-1:0] BRANCH_START_ADDR = 'h0000,
  parameter logic [ADDR_WIDTH-1:0] BRANCH_END_ADDR = 'h00FF,
  parameter int MEM_WORDS = 64
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [ADDR_WIDTH-1:0]     root_awaddr,
  input  logic [AXI_PROT_WIDTH-1:0] root_awprot,
  input  logic                      root_awvalid,
  output logic                      root_awready,
  input  logic [DATA_WIDTH-1:0]     root_wdata,
  input  logic [DATA_WIDTH/8-1:0]   root_wstrb,
  input  logic                      root_wvalid,
  output logic                      root_wready,
  output logic [AXI_RESP_WIDTH-1:0] root_bresp,
  output logic                      root_bvalid,
  input  logic                      root_bready,
  input  logic [ADDR_WIDTH-1:0]     root_araddr,
  input  logic [AXI_PROT_WIDTH-1:0] root_arprot,
  input  logic                      root_arvalid,
  output logic                      root_arready,
  output logic [DATA_WIDTH-1:0]     root_rdata,
  output logic [AXI_RESP_WIDTH-1:0] root_rresp,
  output logic                      root_rvalid,
  input  logic                      root_rready
);

  logic [WAIT_WIDTH-1:0] wait_cycles;

  axil_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) branch_bus ();
  axil_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) trunk_bus ();

  // ------------------------------
  // Address split
  // ------------------------------
  axil_split #(
    .ADDR_WIDTH        (ADDR_WIDTH),
    .DATA_WIDTH        (DATA_WIDTH),
    .BRANCH_START_ADDR (BRANCH_START_ADDR),
    .BRANCH_END_ADDR   (BRANCH_END_ADDR)
  ) axil_split_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .root_awaddr  (root_awaddr),
    .root_awprot  (root_awprot),
    .root_awvalid (root_awvalid),
    .root_awready (root_awready),
    .root_wdata   (root_wdata),
    .root_wstrb   (root_wstrb),
    .root_wvalid  (root_wvalid),
    .root_wready  (root_wready),
    .root_bresp   (root_bresp),
    .root_bvalid  (root_bvalid),
    .root_bready  (root_bready),
    .root_araddr  (root_araddr),
    .root_arprot  (root_arprot),
    .root_arvalid (root_arvalid),
    .root_arready (root_arready),
    .root_rdata   (root_rdata),
    .root_rresp   (root_rresp),
    .root_rvalid  (root_rvalid),
    .root_rready  (root_rready),
    .branch       (branch_bus.initiator),
    .trunk        (trunk_bus.initiator)
  );

  // ------------------------------
  // Targets
  // ------------------------------
  axil_csr_block #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) axil_csr_block_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (branch_bus.target),
    .wait_cycles (wait_cycles)
  );

  // WAIT_CYCLES from the register block sets memory latency
  axil_mem_fsm #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .MEM_WORDS  (MEM_WORDS)
  ) axil_mem_fsm_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (trunk_bus.target),
    .wait_cycles (wait_cycles)
  );

endmodule

`default_nettype wire

//--- filelist.f
axil_pkg.sv
axil_if.sv
rr_arb.sv
axil_split.sv
axil_csr_block.sv
wait_timer.sv
axil_mem_array.sv
axil_mem_fsm.sv
axil_subsys_top.sv
tb_axil_subsys.sv

//--- rr_arb.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arb (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [1:0] request,
  input  logic       update,
  output logic [1:0] grant
);

  logic       last_q;
  logic [1:0] hold_q;
  logic [1:0] fair;

  // On a tie, favor whoever did not win the last transfer
  always_comb begin
    if (request == 2'b11) begin
      fair = last_q ? 2'b01 : 2'b10;
    end else begin
      fair = request;
    end
  end

  // A stalled grant stays put until its transfer completes
  assign grant = (|hold_q) ? hold_q : fair;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_q <= 1'b0;
      hold_q <= 2'b00;
    end else begin
      if (update) begin
        last_q <= grant[1];
      end
      hold_q <= update ? 2'b00 : grant;
    end
  end

  a_grant_legal: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant) && ((grant & ~request) == 2'b00));

endmodule

`default_nettype wire

//--- tb_axil_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axil_subsys import axil_pkg::*; ();

  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int MEM_WORDS = 64;
  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int TIMEOUT = 200;
  localparam logic [15:0] BRANCH_END = 16'h00FF;

  localparam logic [1:0] OP_WRITE = 2'd0;
  localparam logic [1:0] OP_READ = 2'd1;
  localparam logic [1:0] OP_PAIR = 2'd2;

  // A read pair keeps the register address in data[15:0] and its value in rdata
  typedef struct packed {
    logic [1:0]  op;
    logic [15:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [1:0]  resp;
    logic [31:0] rdata;
  } entry_t;

  logic clk;
  logic rst_n;
  logic [ADDR_WIDTH-1:0]     root_awaddr;
  logic [AXI_PROT_WIDTH-1:0] root_awprot;
  logic                      root_awvalid;
  logic                      root_awready;
  logic [DATA_WIDTH-1:0]     root_wdata;
  logic [DATA_WIDTH/8-1:0]   root_wstrb;
  logic                      root_wvalid;
  logic                      root_wready;
  logic [AXI_RESP_WIDTH-1:0] root_bresp;
  logic                      root_bvalid;
  logic                      root_bready;
  logic [ADDR_WIDTH-1:0]     root_araddr;
  logic [AXI_PROT_WIDTH-1:0] root_arprot;
  logic                      root_arvalid;
  logic                      root_arready;
  logic [DATA_WIDTH-1:0]     root_rdata;
  logic [AXI_RESP_WIDTH-1:0] root_rresp;
  logic                      root_rvalid;
  logic                      root_rready;

  entry_t      stim_q[$];
  logic [31:0] mem_model [MEM_WORDS];
  logic [31:0] rng;
  logic [3:0]  cur_wait;

  axil_subsys_top #(
    .ADDR_WIDTH        (ADDR_WIDTH),
    .DATA_WIDTH        (DATA_WIDTH),
    .BRANCH_START_ADDR (16'h0000),
    .BRANCH_END_ADDR   (BRANCH_END),
    .MEM_WORDS         (MEM_WORDS)
  ) axil_subsys_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .root_awaddr  (root_awaddr),
    .root_awprot  (root_awprot),
    .root_awvalid (root_awvalid),
    .root_awready (root_awready),
    .root_wdata   (root_wdata),
    .root_wstrb   (root_wstrb),
    .root_wvalid  (root_wvalid),
    .root_wready  (root_wready),
    .root_bresp   (root_bresp),
    .root_bvalid  (root_bvalid),
    .root_bready  (root_bready),
    .root_araddr  (root_araddr),
    .root_arprot  (root_arprot),
    .root_arvalid (root_arvalid),
    .root_arready (root_arready),
    .root_rdata   (root_rdata),
    .root_rresp   (root_rresp),
    .root_rvalid  (root_rvalid),
    .root_rready  (root_rready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Ready three times out of four
  task automatic next_ready(output logic ready);
    rng = xorshift32(rng);
    ready = (rng[1:0] != 2'b00);
  endtask

  function automatic logic in_mem_window(input logic [15:0] a);
    return (a >= MEM_BASE_ADDR) && (32'(a) < 32'(MEM_BASE_ADDR) + 32'(MEM_WORDS * 4));
  endfunction

  function automatic int model_index(input logic [15:0] a);
    return int'((a - MEM_BASE_ADDR) >> 2);
  endfunction

  task automatic update_model(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s);
    int idx;
    idx = model_index(a);
    for (int b = 0; b < 4; b++) begin
      if (s[b]) begin
        mem_model[idx][b*8 +: 8] = d[b*8 +: 8];
      end
    end
  endtask

  task automatic stop_on_error();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string field, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at time %0t: %s got 0x%08h, expected 0x%08h", $time, field, got, exp);
      stop_on_error();
    end
  endtask

  task automatic report_timeout(input string channel);
    $display("Timeout at time %0t: the %s channel gave no handshake within %0d cycles",
             $time, channel, TIMEOUT);
    stop_on_error();
  endtask

  // ------------------------------
  // Bus tasks are entered at posedge plus drive delay
  // ------------------------------
  task automatic issue_aw_w(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int cycles;
    cycles = 0;
    root_awaddr = addr;
    root_wdata = data;
    root_wstrb = strb;
    root_awvalid = 1'b1;
    root_wvalid = 1'b1;
    @(negedge clk);
    while (!(root_awready && root_wready)) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("AW/W");
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    root_awvalid = 1'b0;
    root_wvalid = 1'b0;
  endtask

  task automatic issue_ar(input logic [15:0] addr);
    int cycles;
    cycles = 0;
    root_araddr = addr;
    root_arvalid = 1'b1;
    @(negedge clk);
    while (!root_arready) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("AR");
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    root_arvalid = 1'b0;
  endtask

  task automatic wait_bresp(output logic [1:0] resp);
    int cycles;
    logic held;
    logic [1:0] held_resp;
    logic done;
    cycles = 0;
    held = 1'b0;
    held_resp = '0;
    done = 1'b0;
    while (!done) begin
      next_ready(root_bready);
      @(negedge clk);
      if (held) begin
        check_value("stalled bvalid", 32'(root_bvalid), 32'd1);
        check_value("stalled bresp", 32'(root_bresp), 32'(held_resp));
      end
      if (root_bvalid && root_bready) begin
        resp = root_bresp;
        done = 1'b1;
      end else begin
        held = root_bvalid;
        held_resp = root_bresp;
        cycles++;
        if (cycles > TIMEOUT) report_timeout("B");
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
    root_bready = 1'b0;
  endtask

  // Latency counts clock edges from the AR transfer to the edge that raises rvalid
  task automatic wait_rresp(output logic [31:0] data, output logic [1:0] resp, output int lat);
    int cycles;
    logic held;
    logic seen;
    logic [31:0] held_data;
    logic [1:0] held_resp;
    logic done;
    cycles = 0;
    lat = 0;
    held = 1'b0;
    seen = 1'b0;
    held_data = '0;
    held_resp = '0;
    done = 1'b0;
    while (!done) begin
      next_ready(root_rready);
      @(negedge clk);
      if (root_rvalid) seen = 1'b1;
      if (!seen) lat++;
      if (held) begin
        check_value("stalled rvalid", 32'(root_rvalid), 32'd1);
        check_value("stalled rdata", root_rdata, held_data);
        check_value("stalled rresp", 32'(root_rresp), 32'(held_resp));
      end
      if (root_rvalid && root_rready) begin
        data = root_rdata;
        resp = root_rresp;
        done = 1'b1;
      end else begin
        held = root_rvalid;
        held_data = root_rdata;
        held_resp = root_rresp;
        cycles++;
        if (cycles > TIMEOUT) report_timeout("R");
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
    root_rready = 1'b0;
  endtask

  task automatic add_entry(input logic [1:0] op, input logic [15:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input logic [1:0] resp, input logic [31:0] rdata);
    entry_t e;
    e.op = op;
    e.addr = addr;
    e.data = data;
    e.strb = strb;
    e.resp = resp;
    e.rdata = rdata;
    stim_q.push_back(e);
  endtask

  task automatic apply_entry(input entry_t e);
    logic [1:0]  resp;
    logic [1:0]  resp_b;
    logic [31:0] data;
    logic [31:0] data_b;
    logic [31:0] mem_exp;
    int lat;
    int lat_b;
    @(posedge clk);
    #DRIVE_DELAY;
    case (e.op)
      OP_WRITE: begin
        issue_aw_w(e.addr, e.data, e.strb);
        wait_bresp(resp);
        check_value("bresp", 32'(resp), 32'(e.resp));
        if (in_mem_window(e.addr)) update_model(e.addr, e.data, e.strb);
        if (e.addr == CSR_ADDR_WAIT && e.strb[0]) cur_wait = e.data[3:0];
      end
      OP_READ: begin
        issue_ar(e.addr);
        wait_rresp(data, resp, lat);
        check_value("rresp", 32'(resp), 32'(e.resp));
        if (in_mem_window(e.addr)) begin
          check_value("rdata", data, mem_model[model_index(e.addr)]);
        end else begin
          check_value("rdata", data, e.rdata);
        end
        // Register block raises rvalid on the accepting edge
        if (e.addr <= BRANCH_END) begin
          check_value("read latency", 32'(lat), 32'd0);
        end else begin
          check_value("read latency", 32'(lat), 32'(cur_wait) + 32'd2);
        end
      end
      default: begin
        // Memory read with a register read right behind it
        issue_ar(e.addr);
        issue_ar(e.data[15:0]);
        wait_rresp(data, resp, lat);
        wait_rresp(data_b, resp_b, lat_b);
        mem_exp = mem_model[model_index(e.addr)];
        if (data === mem_exp && resp === RESP_OKAY) begin
          check_value("pair register rdata", data_b, e.rdata);
          check_value("pair register rresp", 32'(resp_b), 32'(e.resp));
        end else begin
          check_value("pair register rdata", data, e.rdata);
          check_value("pair register rresp", 32'(resp), 32'(e.resp));
          check_value("pair memory rdata", data_b, mem_exp);
          check_value("pair memory rresp", 32'(resp_b), 32'(RESP_OKAY));
        end
      end
    endcase
  endtask

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic build_table();
    // Register block after reset
    add_entry(OP_READ, CSR_ADDR_ID, 32'h0, 4'h0, RESP_OKAY, CSR_ID_VALUE);
    add_entry(OP_READ, CSR_ADDR_SCRATCH, 32'h0, 4'h0, RESP_OKAY, 32'h0);
    add_entry(OP_WRITE, CSR_ADDR_SCRATCH, 32'hA5A5_1234, 4'hF, RESP_OKAY, 32'h0);
    add_entry(OP_WRITE, CSR_ADDR_SCRATCH, 32'hFFFF_FFFF, 4'b0101, RESP_OKAY, 32'h0);
    add_entry(OP_READ, CSR_ADDR_SCRATCH, 32'h0, 4'h0, RESP_OKAY, 32'hA5FF_12FF);
    add_entry(OP_WRITE, CSR_ADDR_ID, 32'hDEAD_BEEF, 4'hF, RESP_SLVERR, 32'h0);
    add_entry(OP_READ, CSR_ADDR_ID, 32'h0, 4'h0, RESP_OKAY, CSR_ID_VALUE);
    add_entry(OP_READ, 16'h000C, 32'h0, 4'h0, RESP_SLVERR, 32'h0);
    add_entry(OP_WRITE, 16'h000C, 32'h1234_5678, 4'hF, RESP_SLVERR, 32'h0);
    // Memory with partial strobes
    add_entry(OP_WRITE, 16'h1000, 32'h1122_3344, 4'hF, RESP_OKAY, 32'h0);
    add_entry(OP_WRITE, 16'h1004, 32'hCAFE_F00D, 4'hF, RESP_OKAY, 32'h0);
    add_entry(OP_WRITE, 16'h10FC, 32'h0102_0304, 4'hF, RESP_OKAY, 32'h0);
    add_entry(OP_WRITE, 16'h1000, 32'hAABB_CCDD, 4'b0010, RESP_OKAY, 32'h0);
    add_entry(OP_WRITE, 16'h1004, 32'h5566_7788, 4'b1100, RESP_OKAY, 32'h0);
    add_entry(OP_READ, 16'h1000, 32'h0, 4'h0, RESP_OKAY, 32'h0);
    add_entry(OP_READ, 16'h1004, 32'h0, 4'h0, RESP_OKAY, 32'h0);
    add_entry(OP_READ, 16'h10FC, 32'h0, 4'h0, RESP_OKAY, 32'h0);
    // Trunk addresses outside the memory window
    add_entry(OP_WRITE, 16'h2000, 32'h9999_9999, 4'hF, RESP_DECERR, 32'h0);
    add_entry(OP_READ, 16'h2000, 32'h0, 4'h0, RESP_DECERR, 32'h0);
    add_entry(OP_WRITE, 16'h1100, 32'h7777_7777, 4'hF, RESP_DECERR, 32'h0);
    add_entry(OP_READ, 16'h1000, 32'h0, 4'h0, RESP_OKAY, 32'h0);
    // Wait states
    add_entry(OP_WRITE, CSR_ADDR_WAIT, 32'h0000_0003, 4'h1, RESP_OKAY, 32'h0);
    add_entry(OP_READ, CSR_ADDR_WAIT, 32'h0, 4'h0, RESP_OKAY, 32'h3);
    add_entry(OP_READ, 16'h1004, 32'h0, 4'h0, RESP_OKAY, 32'h0);
    add_entry(OP_WRITE, CSR_ADDR_WAIT, 32'h0000_000F, 4'h1, RESP_OKAY, 32'h0);
    add_entry(OP_READ, 16'h10FC, 32'h0, 4'h0, RESP_OKAY, 32'h0);
    add_entry(OP_READ, 16'h3000, 32'h0, 4'h0, RESP_DECERR, 32'h0);
    add_entry(OP_PAIR, 16'h1000, 32'(CSR_ADDR_SCRATCH), 4'h0, RESP_OKAY, 32'hA5FF_12FF);
    add_entry(OP_WRITE, CSR_ADDR_WAIT, 32'h0000_0000, 4'h1, RESP_OKAY, 32'h0);
    add_entry(OP_READ, 16'h1000, 32'h0, 4'h0, RESP_OKAY, 32'h0);
    add_entry(OP_PAIR, 16'h1004, 32'(CSR_ADDR_ID), 4'h0, RESP_OKAY, CSR_ID_VALUE);
    // Strobe byte 0 clear leaves WAIT_CYCLES alone
    add_entry(OP_WRITE, CSR_ADDR_WAIT, 32'h0000_0007, 4'b1110, RESP_OKAY, 32'h0);
    add_entry(OP_READ, CSR_ADDR_WAIT, 32'h0, 4'h0, RESP_OKAY, 32'h0);
  endtask

  initial begin
    rst_n = 1'b0;
    root_awaddr = '0;
    root_awprot = '0;
    root_awvalid = 1'b0;
    root_wdata = '0;
    root_wstrb = '0;
    root_wvalid = 1'b0;
    root_bready = 1'b0;
    root_araddr = '0;
    root_arprot = '0;
    root_arvalid = 1'b0;
    root_rready = 1'b0;
    rng = 32'h9b237d33;
    cur_wait = 4'd0;
    build_table();
    repeat (16) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    foreach (stim_q[i]) begin
      apply_entry(stim_q[i]);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- wait_timer.sv
`timescale 1ns/1ps
`default_nettype none

module wait_timer import axil_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load,
  input  logic [WAIT_WIDTH-1:0] load_value,
  output logic                  done
);

  logic [WAIT_WIDTH-1:0] count_q;

  // Counts down to zero and parks there
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= load_value;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign done = (count_q == '0);

  a_load_idle: assert property (@(posedge clk) disable iff (!rst_n) load |-> count_q == '0);

endmodule

`default_nettype wire
